/* frv_pipeline_execute.f */
verilog/frv_exec_pkg.sv
verilog/frv_alu.sv
verilog/frv_branch_unit.sv
verilog/frv_exec_result.sv
verilog/frv_exec_pipe_reg.sv
verilog/frv_pipeline_execute.sv
verif/frv_execute_checker.sv
verif/tb_frv_pipeline_execute.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
    --top-module tb_frv_pipeline_execute \
    -f frv_pipeline_execute.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Raise the error limit so the testbench itself reports the failure
out=$(./obj_dir/sim_tb +verilator+error+limit+100)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

/* verif/frv_execute_checker.sv */
// --------------------
// Execute stage checker
// Reference rules for ALU, CFU and result select,
// checked against the stage outputs by assertions
// --------------------
module frv_execute_checker (
    input logic                  g_clk,
    input logic                  g_resetn,
    input frv_exec_pkg::ex_in_t  i_s2,
    input logic                  i_s2_valid,
    input logic                  o_s2_busy,
    input logic                  i_flush,
    input frv_exec_pkg::ex_out_t o_s3,
    input logic                  o_s3_valid,
    input logic                  i_s3_busy,
    input frv_exec_pkg::ex_fwd_t o_fwd
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned           fail_count = 0;              // Failed assertions so far
    logic                  accept;                      // Transfer into stage
    frv_exec_pkg::ex_out_t exp_next;                    // Reference bundle for i_s2
    frv_exec_pkg::ex_out_t exp_q;                       // Expected o_s3 after accept
    frv_exec_pkg::ex_fwd_t exp_fwd;                     // Expected o_fwd, same cycle

    // --------------------
    // Reference rules
    function automatic logic [31:0] alu_ref(input frv_exec_pkg::ex_uop_t uop,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0] s;
        s = b[4:0];                                     // Shift amount
        case (uop)
            frv_exec_pkg::ALU_ADD:  alu_ref = a + b;
            frv_exec_pkg::ALU_SUB:  alu_ref = a - b;
            frv_exec_pkg::ALU_XOR:  alu_ref = a ^ b;
            frv_exec_pkg::ALU_OR:   alu_ref = a | b;
            frv_exec_pkg::ALU_AND:  alu_ref = a & b;
            frv_exec_pkg::ALU_SLL:  alu_ref = a << s;
            frv_exec_pkg::ALU_SRL:  alu_ref = a >> s;
            frv_exec_pkg::ALU_SRA:  alu_ref = (a >> s) | ({32{a[31]}} & ~(32'hffff_ffff >> s));
            frv_exec_pkg::ALU_ROR:  alu_ref = (a >> s) | (a << (6'd32 - {1'b0, s}));
            frv_exec_pkg::ALU_SLT:  alu_ref = {31'd0, $signed(a) < $signed(b)};
            frv_exec_pkg::ALU_SLTU: alu_ref = {31'd0, a < b};
            default:                alu_ref = '0;
        endcase
    endfunction

    function automatic logic taken_ref(input frv_exec_pkg::ex_uop_t uop,
                                       input logic [31:0] a, input logic [31:0] b);
        case (uop)
            frv_exec_pkg::CFU_BEQ:  taken_ref = a == b;
            frv_exec_pkg::CFU_BNE:  taken_ref = a != b;
            frv_exec_pkg::CFU_BLT:  taken_ref = $signed(a) < $signed(b);
            frv_exec_pkg::CFU_BGE:  taken_ref = $signed(a) >= $signed(b);
            frv_exec_pkg::CFU_BLTU: taken_ref = a < b;
            frv_exec_pkg::CFU_BGEU: taken_ref = a >= b;
            default:                taken_ref = 1'b0;
        endcase
    endfunction

    function automatic frv_exec_pkg::ex_out_t next_ref(input frv_exec_pkg::ex_in_t s2);
        frv_exec_pkg::ex_out_t n;
        logic [31:0]           sum;
        logic [31:0]           tgt;
        sum     = s2.opr_a + s2.opr_b;                  // Address sum
        tgt     = (s2.uop == frv_exec_pkg::CFU_JALR) ? sum : s2.opr_c;
        tgt[0]  = 1'b0;
        n.rd    = s2.rd;
        n.uop   = s2.uop;
        n.fu    = s2.fu;
        n.trap  = s2.trap;
        n.size  = s2.size;
        n.instr = s2.instr;
        n.opr_a = '0;
        if (s2.fu.alu) begin
            n.opr_a = alu_ref(s2.uop, s2.opr_a, s2.opr_b);
        end else if (s2.fu.lsu) begin
            n.opr_a = sum;
        end else if (s2.fu.cfu) begin
            n.opr_a = tgt;
            if (s2.uop[4:3] == 2'b00) begin             // Conditional branch
                n.uop = taken_ref(s2.uop, s2.opr_a, s2.opr_b) ?
                        frv_exec_pkg::CFU_TAKEN : frv_exec_pkg::CFU_NOT_TAKEN;
            end
        end else if (s2.fu.csr) begin
            n.opr_a = s2.opr_a;                         // Passed through
        end
        n.opr_b.data = (s2.fu.lsu || s2.fu.csr) ? s2.opr_c : '0;
        if (s2.trap) begin
            n.opr_b.trap_view.pad   = '0;
            n.opr_b.trap_view.cause = {1'b0, s2.rd};    // Decode trap
        end
        return n;
    endfunction

    // --------------------
    // Expected values
    assign accept   = i_s2_valid && !o_s2_busy;
    assign exp_next = next_ref(i_s2);

    always_comb begin
        exp_fwd.rd    = i_s2.rd;
        exp_fwd.wdata = exp_next.opr_a;
        exp_fwd.load  = i_s2.fu.lsu && i_s2.uop[frv_exec_pkg::LSU_LOAD];
        exp_fwd.csr   = i_s2.fu.csr;
    end

    always_ff @(posedge g_clk) begin
        exp_q <= exp_next;                              // Compared one cycle on
    end

    // --------------------
    // Handshake
    a_reset: assert property (@(posedge g_clk) !g_resetn |=> !o_s3_valid && !o_s2_busy)
        else begin
            fail_count++;
            $error("error o_s3_valid %h o_s2_busy %h after reset, exp 0",
                   $sampled(o_s3_valid), $sampled(o_s2_busy));
        end
    a_idle: assert property (@(posedge g_clk) disable iff (!g_resetn)
                             !accept && !(o_s3_valid && i_s3_busy) |=> !o_s3_valid)
        else begin
            fail_count++;
            $error("error o_s3_valid %h without accepted input or stall, exp 0",
                   $sampled(o_s3_valid));
        end
    a_valid: assert property (@(posedge g_clk) disable iff (!g_resetn)
                              accept && !i_flush |=> o_s3_valid)
        else begin
            fail_count++;
            $error("error o_s3_valid %h after accept, exp 1", $sampled(o_s3_valid));
        end
    a_stall: assert property (@(posedge g_clk) disable iff (!g_resetn)
                              o_s3_valid && i_s3_busy && !i_flush |=> o_s3_valid)
        else begin
            fail_count++;
            $error("error o_s3_valid %h under back-pressure, exp 1", $sampled(o_s3_valid));
        end
    a_flush: assert property (@(posedge g_clk) disable iff (!g_resetn) i_flush |=> !o_s3_valid)
        else begin
            fail_count++;
            $error("error o_s3_valid %h after flush, exp 0", $sampled(o_s3_valid));
        end
    a_busy: assert property (@(posedge g_clk) disable iff (!g_resetn)
                             o_s2_busy == (o_s3_valid && i_s3_busy))
        else begin
            fail_count++;
            $error("error o_s2_busy %h exp %h", $sampled(o_s2_busy),
                   $sampled(o_s3_valid && i_s3_busy));
        end
    a_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
                             o_s3_valid && i_s3_busy |=> $stable(o_s3))
        else begin
            fail_count++;
            $error("error o_s3 %h changed under back-pressure", $sampled(o_s3));
        end

    // --------------------
    // Data path
    a_opr_a: assert property (@(posedge g_clk) disable iff (!g_resetn)
                              accept |=> o_s3.opr_a == exp_q.opr_a)
        else begin
            fail_count++;
            $error("error o_s3.opr_a %h exp %h", $sampled(o_s3.opr_a), $sampled(exp_q.opr_a));
        end
    a_opr_b: assert property (@(posedge g_clk) disable iff (!g_resetn)
                              accept |=> o_s3.opr_b == exp_q.opr_b)
        else begin
            fail_count++;
            $error("error o_s3.opr_b %h exp %h", $sampled(o_s3.opr_b), $sampled(exp_q.opr_b));
        end
    a_uop: assert property (@(posedge g_clk) disable iff (!g_resetn)
                            accept |=> o_s3.uop == exp_q.uop)
        else begin
            fail_count++;
            $error("error o_s3.uop %h exp %h", $sampled(o_s3.uop), $sampled(exp_q.uop));
        end
    a_bundle: assert property (@(posedge g_clk) disable iff (!g_resetn)
                               accept |=> o_s3 == exp_q)
        else begin
            fail_count++;
            $error("error o_s3 %h exp %h", $sampled(o_s3), $sampled(exp_q));
        end
    a_fwd: assert property (@(posedge g_clk) disable iff (!g_resetn) o_fwd == exp_fwd)
        else begin
            fail_count++;
            $error("error o_fwd %h exp %h", $sampled(o_fwd), $sampled(exp_fwd));
        end

endmodule

bind frv_pipeline_execute frv_execute_checker u_checker (
    .g_clk      (g_clk     ),
    .g_resetn   (g_resetn  ),
    .i_s2       (i_s2      ),
    .i_s2_valid (i_s2_valid),
    .o_s2_busy  (o_s2_busy ),
    .i_flush    (i_flush   ),
    .o_s3       (o_s3      ),
    .o_s3_valid (o_s3_valid),
    .i_s3_busy  (i_s3_busy ),
    .o_fwd      (o_fwd     )
);

/* verif/tb_frv_pipeline_execute.sv */
// --------------------
// Execute stage testbench
// Sweeps every unit and micro-op, then random traffic
// with back-pressure and flush; checker is bound to the DUT
// --------------------
module tb_frv_pipeline_execute;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int N_SWEEP      = 64;                   // 4 units x 16 selects
    localparam int N_RANDOM     = 3000;
    localparam int WDOG_CYCLES  = RESET_CYCLES + N_SWEEP + 2 * N_RANDOM + 100;

    logic                  g_clk;
    logic                  g_resetn;
    frv_exec_pkg::ex_in_t  i_s2;
    logic                  i_s2_valid;
    logic                  o_s2_busy;
    logic                  i_flush;
    frv_exec_pkg::ex_out_t o_s3;
    logic                  o_s3_valid;
    logic                  i_s3_busy;
    frv_exec_pkg::ex_fwd_t o_fwd;
    logic [31:0]           lcg_state;                   // Random state
    logic [31:0]           r;
    logic                  stall;                       // Upstream item held

    frv_pipeline_execute u_dut (
        .g_clk      (g_clk     ),
        .g_resetn   (g_resetn  ),
        .i_s2       (i_s2      ),
        .i_s2_valid (i_s2_valid),
        .o_s2_busy  (o_s2_busy ),
        .i_flush    (i_flush   ),
        .o_s3       (o_s3      ),
        .o_s3_valid (o_s3_valid),
        .i_s3_busy  (i_s3_busy ),
        .o_fwd      (o_fwd     )
    );

    // --------------------
    // Helpers
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        lcg_next = s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_rand(output logic [31:0] v);
        lcg_state = lcg_next(lcg_state);
        v = lcg_state;
    endtask

    function automatic frv_exec_pkg::ex_uop_t pick_uop(input logic [1:0] unit,
                                                       input logic [3:0] sel,
                                                       input logic [4:0] rnd);
        pick_uop = rnd;                                 // CSR takes any code
        if (unit == 2'd0) begin
            case (sel)
                4'd0:    pick_uop = frv_exec_pkg::ALU_ADD;
                4'd1:    pick_uop = frv_exec_pkg::ALU_SUB;
                4'd2:    pick_uop = frv_exec_pkg::ALU_XOR;
                4'd3:    pick_uop = frv_exec_pkg::ALU_OR;
                4'd4:    pick_uop = frv_exec_pkg::ALU_AND;
                4'd5:    pick_uop = frv_exec_pkg::ALU_SLL;
                4'd6:    pick_uop = frv_exec_pkg::ALU_SRL;
                4'd7:    pick_uop = frv_exec_pkg::ALU_SRA;
                4'd8:    pick_uop = frv_exec_pkg::ALU_ROR;
                4'd9:    pick_uop = frv_exec_pkg::ALU_SLT;
                default: pick_uop = frv_exec_pkg::ALU_SLTU;
            endcase
        end else if (unit == 2'd1) begin
            pick_uop = {~sel[0], sel[0], rnd[2:0]};     // Store or load bit
        end else if (unit == 2'd2) begin
            case (sel)
                4'd0:    pick_uop = frv_exec_pkg::CFU_BEQ;
                4'd1:    pick_uop = frv_exec_pkg::CFU_BNE;
                4'd2:    pick_uop = frv_exec_pkg::CFU_BLT;
                4'd3:    pick_uop = frv_exec_pkg::CFU_BGE;
                4'd4:    pick_uop = frv_exec_pkg::CFU_BLTU;
                4'd5:    pick_uop = frv_exec_pkg::CFU_BGEU;
                4'd6:    pick_uop = frv_exec_pkg::CFU_JMP;
                4'd7:    pick_uop = frv_exec_pkg::CFU_JALI;
                default: pick_uop = frv_exec_pkg::CFU_JALR;
            endcase
        end
    endfunction

    // New upstream item, unit one-hot with ALU at the top
    task automatic new_item(input logic [1:0] unit, input logic [3:0] sel, input logic trap);
        logic [31:0] v;
        next_rand(v);
        i_s2.rd    = v[4:0];
        i_s2.uop   = pick_uop(unit, sel, v[9:5]);
        i_s2.size  = v[11:10];
        i_s2.fu    = 4'b1000 >> unit;
        i_s2.trap  = trap;
        next_rand(i_s2.opr_a);
        next_rand(i_s2.opr_b);
        if (v[13:12] == 2'b00) begin
            i_s2.opr_b = i_s2.opr_a;                    // Equal compare
        end else if (v[13:12] == 2'b01) begin
            i_s2.opr_b[31] = ~i_s2.opr_a[31];           // Mixed signs
        end
        next_rand(i_s2.opr_c);
        next_rand(i_s2.instr);
    endtask

    // --------------------
    // Clock and watchdog
    initial begin
        g_clk = 1'b0;
        forever #(CLK_PERIOD / 2) g_clk = ~g_clk;
    end

    initial begin
        #(WDOG_CYCLES * CLK_PERIOD);
        $display("STATUS: FAIL");
        $fatal(1, "Watchdog expired before the stimulus finished");
    end

    always @(negedge g_clk) begin
        if (u_dut.u_checker.fail_count != 0) begin
            $display("STATUS: FAIL");
            $fatal(1, "Checker assertion failed");
        end
    end

    // --------------------
    // Stimulus
    initial begin
        g_resetn   = 1'b0;
        i_s2       = '0;
        i_s2_valid = 1'b0;
        i_flush    = 1'b0;
        i_s3_busy  = 1'b0;
        stall      = 1'b0;
        lcg_state  = 32'hdcfd_76f3;
        repeat (RESET_CYCLES) @(posedge g_clk);
        #1 g_resetn = 1'b1;

        // Every unit and micro-op, no back-pressure
        for (int u = 0; u < 4; u++) begin
            for (int s = 0; s < 16; s++) begin
                @(posedge g_clk);
                #1;
                new_item(u[1:0], s[3:0], s[1:0] == 2'd3);
                i_s2_valid = 1'b1;
            end
        end

        // Random traffic, held item waits for acceptance
        for (int n = 0; n < N_RANDOM; n++) begin
            @(negedge g_clk);
            stall = i_s2_valid && o_s2_busy;
            @(posedge g_clk);
            #1;
            next_rand(r);
            if (!stall) begin
                new_item(r[1:0], r[5:2], r[8:6] == 3'd0);
                i_s2_valid = r[11:9] != 3'd0;
            end
            i_s3_busy = r[13:12] == 2'b11 || r[14];
            i_flush   = r[19:16] == 4'hf;
        end

        @(posedge g_clk);
        #1;
        i_s2_valid = 1'b0;
        i_s3_busy  = 1'b0;
        i_flush    = 1'b0;
        repeat (3) @(posedge g_clk);
        @(negedge g_clk);
        if (u_dut.u_checker.fail_count != 0) begin
            $display("STATUS: FAIL");
            $fatal(1, "Checker assertion failed");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

/* verilog/frv_alu.sv */
// --------------------
// Integer ALU
// Add/sub, logic ops, shifts, rotate and compares,
// also the compare source for conditional branches
// --------------------
module frv_alu (
    input  frv_exec_pkg::ex_in_t          i_s2,          // Stage 2 instruction
    output logic [frv_exec_pkg::XLEN-1:0] o_add_result,  // Always A + B
    output logic [frv_exec_pkg::XLEN-1:0] o_result,      // Selected ALU result
    output logic                          o_lt,          // A < B, signedness by op
    output logic                          o_eq           // A == B
);

    localparam int XLEN = frv_exec_pkg::XLEN;
    localparam int XL   = XLEN - 1;                      // MSB index

    logic [XL:0]       lhs;                              // Operand A
    logic [XL:0]       rhs;                              // Operand B
    logic [4:0]        shamt;                            // Shift amount
    logic              fu_alu;
    logic              cfu_cond;                         // Branch compare
    logic              op_add;
    logic              op_sub;
    logic              op_xor;
    logic              op_or;
    logic              op_and;
    logic              op_sll;
    logic              op_srl;
    logic              op_sra;
    logic              op_ror;
    logic              op_slt;                           // slt or sltu
    logic              op_unsigned;                      // Unsigned compare
    logic [XLEN:0]     diff;                             // A - B with borrow out
    logic [XL:0]       sll_res;
    logic [XL:0]       srl_res;
    logic [XL:0]       sra_res;
    logic [2*XLEN-1:0] ror_wide;                         // Doubled word, shifted

    assign lhs   = i_s2.opr_a;
    assign rhs   = i_s2.opr_b;
    assign shamt = i_s2.opr_b[4:0];

    // --------------------
    // Op decode
    assign fu_alu   = i_s2.fu.alu;
    assign cfu_cond = i_s2.fu.cfu && i_s2.uop[4:3] == 2'b00;

    assign op_add = fu_alu && i_s2.uop == frv_exec_pkg::ALU_ADD;
    assign op_sub = fu_alu && i_s2.uop == frv_exec_pkg::ALU_SUB;
    assign op_xor = fu_alu && i_s2.uop == frv_exec_pkg::ALU_XOR;
    assign op_or  = fu_alu && i_s2.uop == frv_exec_pkg::ALU_OR;
    assign op_and = fu_alu && i_s2.uop == frv_exec_pkg::ALU_AND;
    assign op_sll = fu_alu && i_s2.uop == frv_exec_pkg::ALU_SLL;
    assign op_srl = fu_alu && i_s2.uop == frv_exec_pkg::ALU_SRL;
    assign op_sra = fu_alu && i_s2.uop == frv_exec_pkg::ALU_SRA;
    assign op_ror = fu_alu && i_s2.uop == frv_exec_pkg::ALU_ROR;
    assign op_slt = fu_alu && (i_s2.uop == frv_exec_pkg::ALU_SLT ||
                               i_s2.uop == frv_exec_pkg::ALU_SLTU);

    assign op_unsigned = fu_alu && i_s2.uop == frv_exec_pkg::ALU_SLTU ||
                         cfu_cond && (i_s2.uop == frv_exec_pkg::CFU_BLTU ||
                                      i_s2.uop == frv_exec_pkg::CFU_BGEU);

    // --------------------
    // Adder and compare
    assign o_add_result = lhs + rhs;                     // Also LSU / JALR address
    assign diff         = {1'b0, lhs} - {1'b0, rhs};     // Borrow gives unsigned lt

    assign o_eq = lhs == rhs;
    assign o_lt = op_unsigned            ? diff[XLEN] :  // Borrow out
                  (lhs[XL] != rhs[XL])   ? lhs[XL]    :  // Signs differ
                                           diff[XL];     // Same sign, check diff

    // --------------------
    // Shifter
    assign sll_res  = lhs << shamt;
    assign srl_res  = lhs >> shamt;
    assign sra_res  = $unsigned($signed(lhs) >>> shamt);
    assign ror_wide = {lhs, lhs} >> shamt;               // Low half is the rotate

    // One-hot result select
    assign o_result = {XLEN{op_add}} & o_add_result      |
                      {XLEN{op_sub}} & diff[XL:0]        |
                      {XLEN{op_xor}} & (lhs ^ rhs)       |
                      {XLEN{op_or }} & (lhs | rhs)       |
                      {XLEN{op_and}} & (lhs & rhs)       |
                      {XLEN{op_sll}} & sll_res           |
                      {XLEN{op_srl}} & srl_res           |
                      {XLEN{op_sra}} & sra_res           |
                      {XLEN{op_ror}} & ror_wide[XL:0]    |
                      {XLEN{op_slt}} & {{XL{1'b0}}, o_lt};

endmodule

/* verilog/frv_branch_unit.sv */
// --------------------
// Control flow unit
// Resolves branches to taken / not taken and
// forms the jump or branch target
// --------------------
module frv_branch_unit (
    input  frv_exec_pkg::ex_in_t          i_s2,          // Stage 2 instruction
    input  logic                          i_lt,          // From ALU compare
    input  logic                          i_eq,          // From ALU compare
    input  logic [frv_exec_pkg::XLEN-1:0] i_add_result,  // A + B, JALR address
    output frv_exec_pkg::ex_uop_t         o_uop,         // Resolved micro-op
    output logic [frv_exec_pkg::XLEN-1:0] o_target       // Halfword aligned target
);

    localparam int XL = frv_exec_pkg::XLEN - 1;

    logic fu_cfu;
    logic cfu_cond;                                      // Class 00
    logic cfu_jalr;
    logic cond_beq;
    logic cond_bne;
    logic cond_blt;
    logic cond_bge;
    logic cond_bltu;
    logic cond_bgeu;
    logic cond_taken;

    assign fu_cfu   = i_s2.fu.cfu;
    assign cfu_cond = fu_cfu && i_s2.uop[4:3] == 2'b00;
    assign cfu_jalr = fu_cfu && i_s2.uop == frv_exec_pkg::CFU_JALR;

    // --------------------
    // Condition decode
    assign cond_beq  = cfu_cond && i_s2.uop == frv_exec_pkg::CFU_BEQ;
    assign cond_bne  = cfu_cond && i_s2.uop == frv_exec_pkg::CFU_BNE;
    assign cond_blt  = cfu_cond && i_s2.uop == frv_exec_pkg::CFU_BLT;
    assign cond_bge  = cfu_cond && i_s2.uop == frv_exec_pkg::CFU_BGE;
    assign cond_bltu = cfu_cond && i_s2.uop == frv_exec_pkg::CFU_BLTU;
    assign cond_bgeu = cfu_cond && i_s2.uop == frv_exec_pkg::CFU_BGEU;

    // ALU already picked signed or unsigned lt
    assign cond_taken = cond_beq  &&  i_eq ||
                        cond_bne  && !i_eq ||
                        cond_blt  &&  i_lt ||
                        cond_bltu &&  i_lt ||
                        cond_bge  && !i_lt ||
                        cond_bgeu && !i_lt;

    assign o_uop = !cfu_cond  ? i_s2.uop                    :  // Jumps unchanged
                   cond_taken ? frv_exec_pkg::CFU_TAKEN     :
                                frv_exec_pkg::CFU_NOT_TAKEN;

    // Bit 0 always cleared
    assign o_target = cfu_jalr ? {i_add_result[XL:1], 1'b0} :
                                 {i_s2.opr_c[XL:1],   1'b0};

endmodule

/* verilog/frv_exec_pipe_reg.sv */
// --------------------
// Execute stage register
// Single entry with valid/busy handshake and flush
// --------------------
module frv_exec_pipe_reg (
    input  logic                  g_clk,
    input  logic                  g_resetn,      // Sync, active low
    input  frv_exec_pkg::ex_out_t i_data,        // From result select
    input  logic                  i_valid,       // Upstream valid
    input  logic                  i_flush,       // Kill held entry
    input  logic                  i_busy,        // Downstream stalled
    output frv_exec_pkg::ex_out_t o_data,        // Stage 3 contents
    output logic                  o_valid,       // Stage 3 valid
    output logic                  o_busy         // Stall upstream
);

    logic load;                                  // Accept this cycle

    // Unbuffered handshake, stall only while output is held
    assign o_busy = o_valid && i_busy;
    assign load   = i_valid && !o_busy;

    // --------------------
    // Valid bit
    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            o_valid <= 1'b0;                     // Flush wins over load
        end else if (!o_busy) begin
            o_valid <= i_valid;                  // Drain or refill
        end
    end

    // Payload
    always_ff @(posedge g_clk) begin
        if (load) begin
            o_data <= i_data;
        end
    end

endmodule

/* verilog/frv_exec_pkg.sv */
// --------------------
// Execute stage package
// Data width, unit and micro-op encodings, and the
// stage-2 / stage-3 / forwarding bundles
// --------------------
package frv_exec_pkg;

    localparam int XLEN = 32;                        // Data word width

    typedef logic [4:0] ex_uop_t;                    // Micro-op code
    typedef logic [5:0] ex_trap_cause_t;             // Trap cause code

    // One-hot functional unit select
    typedef struct packed {
        logic alu;                                   // Integer ALU
        logic lsu;                                   // Load / store unit
        logic cfu;                                   // Control flow unit
        logic csr;                                   // CSR access
    } ex_fu_t;

    // --------------------
    // ALU micro-ops
    localparam ex_uop_t ALU_ADD  = 5'b00_001;
    localparam ex_uop_t ALU_SUB  = 5'b00_000;
    localparam ex_uop_t ALU_XOR  = 5'b01_001;
    localparam ex_uop_t ALU_OR   = 5'b01_010;
    localparam ex_uop_t ALU_AND  = 5'b01_100;
    localparam ex_uop_t ALU_SLL  = 5'b10_001;
    localparam ex_uop_t ALU_SRL  = 5'b10_010;
    localparam ex_uop_t ALU_SRA  = 5'b10_100;
    localparam ex_uop_t ALU_ROR  = 5'b10_110;
    localparam ex_uop_t ALU_SLT  = 5'b11_001;
    localparam ex_uop_t ALU_SLTU = 5'b11_010;

    // --------------------
    // CFU micro-ops, top two bits give the class
    localparam ex_uop_t CFU_BEQ       = 5'b00_001;   // Conditional class 00
    localparam ex_uop_t CFU_BGE       = 5'b00_010;
    localparam ex_uop_t CFU_BGEU      = 5'b00_011;
    localparam ex_uop_t CFU_BLT       = 5'b00_100;
    localparam ex_uop_t CFU_BLTU      = 5'b00_101;
    localparam ex_uop_t CFU_BNE       = 5'b00_110;
    localparam ex_uop_t CFU_NOT_TAKEN = 5'b01_000;   // Resolved branch results
    localparam ex_uop_t CFU_TAKEN     = 5'b01_001;
    localparam ex_uop_t CFU_JMP       = 5'b10_001;   // Jump class 10
    localparam ex_uop_t CFU_JALI      = 5'b10_010;
    localparam ex_uop_t CFU_JALR      = 5'b10_100;

    // LSU micro-op bit positions
    localparam int LSU_LOAD  = 3;                    // Set for loads
    localparam int LSU_STORE = 4;                    // Set for stores

    // Trap view of operand B
    typedef struct packed {
        logic [XLEN-7:0] pad;                        // Always zero
        ex_trap_cause_t  cause;                      // Cause code
    } ex_trap_view_t;

    // Stage 3 operand B, data or trap cause
    typedef union packed {
        logic [XLEN-1:0] data;                       // Store data / CSR operand
        ex_trap_view_t   trap_view;                  // Valid when trap is set
    } ex_opr_b_u;

    // Stage 2 input bundle
    typedef struct packed {
        logic [4:0]      rd;                         // Destination register
        logic [XLEN-1:0] opr_a;                      // Operand A
        logic [XLEN-1:0] opr_b;                      // Operand B
        logic [XLEN-1:0] opr_c;                      // Operand C
        ex_uop_t         uop;                        // Micro-op
        ex_fu_t          fu;                         // Functional unit
        logic            trap;                       // Trap raised in decode
        logic [1:0]      size;                       // Instruction size
        logic [31:0]     instr;                      // Instruction word
    } ex_in_t;

    // Stage 3 output bundle
    typedef struct packed {
        logic [4:0]      rd;                         // Destination register
        logic [XLEN-1:0] opr_a;                      // Result / address / target
        ex_opr_b_u       opr_b;                      // Data or trap cause
        ex_uop_t         uop;                        // Micro-op, resolved for CFU
        ex_fu_t          fu;                         // Functional unit
        logic            trap;                       // Trap pending
        logic [1:0]      size;                       // Instruction size
        logic [31:0]     instr;                      // Instruction word
    } ex_out_t;

    // Forwarding bundle back to decode
    typedef struct packed {
        logic [4:0]      rd;                         // Destination register
        logic [XLEN-1:0] wdata;                      // Value to forward
        logic            load;                       // Load in flight, no data yet
        logic            csr;                        // CSR op in flight
    } ex_fwd_t;

endpackage

/* verilog/frv_exec_result.sv */
// --------------------
// Execute result select
// Builds the next stage 3 bundle by unit and the
// same-cycle forwarding value
// --------------------
module frv_exec_result (
    input  frv_exec_pkg::ex_in_t          i_s2,          // Stage 2 instruction
    input  logic [frv_exec_pkg::XLEN-1:0] i_alu_result,  // ALU result
    input  logic [frv_exec_pkg::XLEN-1:0] i_add_result,  // LSU address
    input  frv_exec_pkg::ex_uop_t         i_cfu_uop,     // Resolved CFU micro-op
    input  logic [frv_exec_pkg::XLEN-1:0] i_cfu_target,  // CFU target
    output frv_exec_pkg::ex_out_t         o_next,        // Next stage 3 contents
    output frv_exec_pkg::ex_fwd_t         o_fwd          // Forwarding info
);

    localparam int XLEN = frv_exec_pkg::XLEN;

    frv_exec_pkg::ex_fu_t    fu;
    logic [XLEN-1:0]         n_opr_a;                    // Next operand A
    frv_exec_pkg::ex_opr_b_u n_opr_b;                    // Next operand B
    logic                    lsu_load;

    assign fu       = i_s2.fu;
    assign lsu_load = fu.lsu && i_s2.uop[frv_exec_pkg::LSU_LOAD];

    // --------------------
    // Operand A by unit
    assign n_opr_a = {XLEN{fu.alu}} & i_alu_result |
                     {XLEN{fu.lsu}} & i_add_result |     // Memory address
                     {XLEN{fu.cfu}} & i_cfu_target |
                     {XLEN{fu.csr}} & i_s2.opr_a;        // CSR write value

    // Operand B, trap view overrides data
    always_comb begin
        n_opr_b.data = {XLEN{fu.lsu | fu.csr}} & i_s2.opr_c;
        if (i_s2.trap) begin
            n_opr_b.trap_view.pad   = '0;
            n_opr_b.trap_view.cause = {1'b0, i_s2.rd};   // Decode trap cause
        end
    end

    // --------------------
    // Next stage bundle
    always_comb begin
        o_next.rd    = i_s2.rd;
        o_next.opr_a = n_opr_a;
        o_next.opr_b = n_opr_b;
        o_next.uop   = fu.cfu ? i_cfu_uop : i_s2.uop;    // Branch outcome for CFU
        o_next.fu    = i_s2.fu;
        o_next.trap  = i_s2.trap;
        o_next.size  = i_s2.size;
        o_next.instr = i_s2.instr;
    end

    // Forwarding, same cycle as stage 2
    always_comb begin
        o_fwd.rd    = i_s2.rd;
        o_fwd.wdata = n_opr_a;                           // Not final for loads
        o_fwd.load  = lsu_load;
        o_fwd.csr   = fu.csr;
    end

endmodule

/* verilog/frv_pipeline_execute.sv */
// --------------------
// Execute stage top
// ALU, CFU, result select and stage register
// --------------------
module frv_pipeline_execute (
    input  logic                  g_clk,
    input  logic                  g_resetn,      // Sync, active low

    input  frv_exec_pkg::ex_in_t  i_s2,          // Decoded instruction
    input  logic                  i_s2_valid,    // Stage 2 valid
    output logic                  o_s2_busy,     // Stall stage 2

    input  logic                  i_flush,       // Flush stage 3

    output frv_exec_pkg::ex_out_t o_s3,          // To write-back
    output logic                  o_s3_valid,    // Stage 3 valid
    input  logic                  i_s3_busy,     // Write-back stalled

    output frv_exec_pkg::ex_fwd_t o_fwd          // Forwarding to decode
);

    logic [frv_exec_pkg::XLEN-1:0] alu_add_result;   // A + B
    logic [frv_exec_pkg::XLEN-1:0] alu_result;
    logic                          alu_lt;
    logic                          alu_eq;
    frv_exec_pkg::ex_uop_t         cfu_uop;          // Resolved branch op
    logic [frv_exec_pkg::XLEN-1:0] cfu_target;
    frv_exec_pkg::ex_out_t         n_s3;             // Next stage 3 bundle

    // --------------------
    // Units
    frv_alu u_alu (
        .i_s2         (i_s2          ),
        .o_add_result (alu_add_result),
        .o_result     (alu_result    ),
        .o_lt         (alu_lt        ),
        .o_eq         (alu_eq        )
    );

    frv_branch_unit u_branch_unit (
        .i_s2         (i_s2          ),
        .i_lt         (alu_lt        ),
        .i_eq         (alu_eq        ),
        .i_add_result (alu_add_result),
        .o_uop        (cfu_uop       ),
        .o_target     (cfu_target    )
    );

    frv_exec_result u_exec_result (
        .i_s2         (i_s2          ),
        .i_alu_result (alu_result    ),
        .i_add_result (alu_add_result),
        .i_cfu_uop    (cfu_uop       ),
        .i_cfu_target (cfu_target    ),
        .o_next       (n_s3          ),
        .o_fwd        (o_fwd         )
    );

    // --------------------
    // Stage register
    frv_exec_pipe_reg u_pipe_reg (
        .g_clk        (g_clk         ),
        .g_resetn     (g_resetn      ),
        .i_data       (n_s3          ),
        .i_valid      (i_s2_valid    ),  // Acceptance gated inside
        .i_flush      (i_flush       ),
        .i_busy       (i_s3_busy     ),
        .o_data       (o_s3          ),
        .o_valid      (o_s3_valid    ),
        .o_busy       (o_s2_busy     )
    );

endmodule
